/* verilog.f */
+incdir+include
logic/isaPkg.sv
logic/pipePkg.sv
logic/pipeStageReg.sv
logic/fetchUnit.sv
logic/decodeUnit.sv
logic/executeUnit.sv
logic/memoryUnit.sv
logic/hazardControl.sv
logic/pipelineCore.sv
tb/tbMemory.sv
tb/coreTb.sv

/* run.sh */
#!/bin/sh
# Build and run the core testbench with Verilator

cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -j 0 --top-module coreTb -f verilog.f -o coreSim
if [ $? -ne 0 ]; then
	echo "Verilator compile failed"
	exit 1
fi

./obj_dir/coreSim > sim.log 2>&1
status=$?
cat sim.log
if [ $status -ne 0 ]; then
	echo "Simulation exited with status $status"
	exit 1
fi

if grep -q "^RESULT: PASS$" sim.log; then
	exit 0
fi
exit 1

/* tb/coreTb.sv */
// Pipeline core testbench

`timescale 1ns/100ps

module coreTb;
	import isaPkg::*;
	import pipePkg::*;

	localparam int PROG_LEN = 32;
	localparam int MEM_WORDS = 256;
	localparam int MAX_DELAY = 3;
	localparam int NUM_TESTS = 9;
	localparam int SEED = 32'hcae0;
	localparam int WATCHDOG = PROG_LEN * 8 * NUM_TESTS + NUM_TESTS * 20;

	logic clk;
	logic rst_n;
	int maxDelay;
	instrReqT instrReq;
	instrT instrData;
	logic instrReady;
	dataReqT dataReq;
	logic [31:0] dataRdData;
	logic dataReady;
	logic halt;

	logic [31:0] prog [PROG_LEN];
	logic [31:0] expAddr [$];
	logic [31:0] expData [$];
	logic checking;
	int errors;
	int testsPassed;
	int testsFailed;
	string currentTest;

	pipelineCore UUT (
		.clk(clk),
		.rst_n(rst_n),
		.instrReq(instrReq),
		.instrData(instrData),
		.instrReady(instrReady),
		.dataReq(dataReq),
		.dataRdData(dataRdData),
		.dataReady(dataReady),
		.halt(halt)
	);

	tbMemory mem (
		.clk(clk),
		.rst_n(rst_n),
		.maxDelay(maxDelay),
		.instrReq(instrReq),
		.instrData(instrData),
		.instrReady(instrReady),
		.dataReq(dataReq),
		.dataRdData(dataRdData),
		.dataReady(dataReady)
	);

	initial begin
		clk = 1'b0;
		forever #10 clk = ~clk;
	end

	function automatic logic [31:0] encodeReg(input int op, input int rd, input int rs,
		input int rt);
		return {op[5:0], rd[4:0], rs[4:0], rt[4:0], 11'b0};
	endfunction

	function automatic logic [31:0] encodeImm(input int op, input int rd, input int rs,
		input int imm);
		return {op[5:0], rd[4:0], rs[4:0], imm[15:0]};
	endfunction

	// Depends on every address bit
	function automatic logic [31:0] fillWord(input int idx);
		return (idx * 32'h9e37_79b1) ^ {idx[7:0], ~idx[7:0], idx[7:0], 8'h5a};
	endfunction

	// ISA interpreter producing the ordered store list
	function automatic void buildExpected();
		logic [31:0] regs [32];
		logic [31:0] dm [MEM_WORDS];
		logic [31:0] w;
		logic [31:0] a;
		logic [31:0] b;
		logic [31:0] imm;
		logic [31:0] res;
		int op;
		int rd;
		expAddr.delete();
		expData.delete();
		foreach (regs[i])
			regs[i] = '0;
		foreach (dm[i])
			dm[i] = fillWord(i);
		for (int pc = 0; pc < PROG_LEN; pc++) begin
			w = prog[pc];
			op = int'(w[31:26]);
			rd = int'(w[25:21]);
			a = regs[w[20:16]];
			b = regs[w[15:11]];
			imm = {{16{w[15]}}, w[15:0]};
			if (op == 63)
				break;
			res = '0;
			case (op)
				1: res = a + b;
				2: res = a - b;
				3: res = a & b;
				4: res = a | b;
				5: res = a ^ b;
				6: res = {31'b0, $signed(a) < $signed(b)};
				7: res = a + imm;
				8: res = dm[(a + imm) >> 2];
				9: begin
					expAddr.push_back(a + imm);
					expData.push_back(regs[rd]);
					dm[(a + imm) >> 2] = regs[rd];
				end
				default: ;
			endcase
			if (op >= 1 && op <= 8 && rd != 0)
				regs[rd] = res;
		end
	endfunction

	// Store checker
	always @(posedge clk) begin
		if (rst_n && checking) begin
			if (dataReq.valid && dataReq.write && dataReady) begin
				if (expAddr.size() == 0) begin
					$display("Unexpected store to %h at %0t", dataReq.addr, $time);
					errors++;
				end else begin
					if (dataReq.addr != expAddr[0]) begin
						$display("ERR %0t dataReq.addr expected %h got %h", $time,
							expAddr[0], dataReq.addr);
						errors++;
					end
					if (dataReq.wrData != expData[0]) begin
						$display("ERR %0t dataReq.wrData expected %h got %h", $time,
							expData[0], dataReq.wrData);
						errors++;
					end
					void'(expAddr.pop_front());
					void'(expData.pop_front());
				end
			end
			if (halt && dataReq.valid) begin
				$display("ERR %0t dataReq.valid expected 0 got %b", $time, dataReq.valid);
				errors++;
			end
		end
	end

	task automatic runTest(input string name, input int delay);
		int startErrors;
		startErrors = errors;
		currentTest = name;
		for (int i = 0; i < MEM_WORDS; i++) begin
			mem.imem[i] = (i < PROG_LEN) ? prog[i] : '0;
			mem.dmem[i] = fillWord(i);
		end
		buildExpected();
		@(negedge clk);
		rst_n = 1'b0;
		maxDelay = delay;
		repeat (10) @(negedge clk);
		rst_n = 1'b1;
		checking = 1'b1;
		if (halt !== 1'b0) begin
			$display("ERR %0t halt expected 0 got %b", $time, halt);
			errors++;
		end
		if (dataReq.valid !== 1'b0) begin
			$display("ERR %0t dataReq.valid expected 0 got %b", $time, dataReq.valid);
			errors++;
		end
		if (instrReq.addr !== 32'h0) begin
			$display("ERR %0t instrReq.addr expected %h got %h", $time, 32'h0,
				instrReq.addr);
			errors++;
		end
		while (!halt)
			@(negedge clk);
		if (expAddr.size() != 0) begin
			$display("Halt rose with %0d stores still missing", expAddr.size());
			errors++;
		end
		repeat (5) begin
			@(negedge clk);
			if (instrReq.valid) begin
				$display("ERR %0t instrReq.valid expected 0 got %b", $time,
					instrReq.valid);
				errors++;
			end
		end
		checking = 1'b0;
		if (errors == startErrors) begin
			testsPassed++;
			$display("Test %s passed", name);
		end else begin
			testsFailed++;
			$display("Test %s failed with %0d errors", name, errors - startErrors);
		end
	endtask

	task automatic makeRandomProgram();
		int kind;
		int len;
		len = PROG_LEN - 4;
		padProgram();
		// Give r1..r7 known values first
		for (int r = 1; r < 8; r++)
			prog[r - 1] = encodeImm(7, r, 0, $urandom_range(16'hffff, 0));
		for (int i = 7; i < len; i++) begin
			kind = $urandom_range(9, 0);
			if (kind <= 5)
				prog[i] = encodeReg(kind + 1, $urandom_range(7, 0), $urandom_range(7, 0),
					$urandom_range(7, 0));
			else if (kind == 6)
				prog[i] = encodeImm(7, $urandom_range(7, 0), $urandom_range(7, 0),
					$urandom_range(16'hffff, 0));
			else if (kind == 7)
				prog[i] = encodeImm(8, $urandom_range(7, 0), 0, $urandom_range(255, 0) * 4);
			else
				prog[i] = encodeImm(9, $urandom_range(7, 0), 0, $urandom_range(255, 0) * 4);
		end
		prog[len] = encodeImm(63, 0, 0, 0);
	endtask

	// Slots past HALT hold stores that must never reach the data port
	task automatic padProgram();
		for (int i = 0; i < PROG_LEN; i++)
			prog[i] = encodeImm(9, 1, 0, 16'h3fc);
	endtask

	initial begin
		repeat (WATCHDOG) @(posedge clk);
		$display("Watchdog expired during test %s, halt never rose", currentTest);
		$display("RESULT: FAIL");
		$finish;
	end

	initial begin
		void'($urandom(SEED));
		rst_n = 1'b0;
		maxDelay = 0;
		checking = 1'b0;
		errors = 0;
		testsPassed = 0;
		testsFailed = 0;

		// Back-to-back dependent ALU chain
		padProgram();
		prog[0] = encodeImm(7, 1, 0, 5);
		prog[1] = encodeImm(7, 2, 1, 7);
		prog[2] = encodeReg(1, 3, 1, 2);
		prog[3] = encodeReg(2, 4, 3, 1);
		prog[4] = encodeReg(5, 5, 4, 3);
		prog[5] = encodeReg(3, 6, 5, 3);
		prog[6] = encodeReg(4, 7, 6, 1);
		prog[7] = encodeReg(6, 8, 1, 4);
		prog[8] = encodeImm(7, 9, 8, -3);
		for (int i = 0; i < 9; i++)
			prog[9 + i] = encodeImm(9, i + 1, 0, 4 * i);
		prog[18] = encodeImm(63, 0, 0, 0);
		runTest("forwarding", 0);

		// Load result used in the next slot
		padProgram();
		prog[0] = encodeImm(7, 1, 0, 16'h55);
		prog[1] = encodeImm(9, 1, 0, 16'h40);
		prog[2] = encodeImm(8, 2, 0, 16'h40);
		prog[3] = encodeReg(1, 3, 2, 2);
		prog[4] = encodeImm(9, 3, 0, 16'h44);
		prog[5] = encodeImm(8, 4, 0, 16'h80);
		prog[6] = encodeImm(9, 4, 0, 16'h48);
		prog[7] = encodeImm(63, 0, 0, 0);
		runTest("loadUse", 0);

		padProgram();
		prog[0] = encodeImm(7, 0, 0, 99);
		prog[1] = encodeReg(1, 0, 0, 0);
		prog[2] = encodeImm(9, 0, 0, 16'h80);
		prog[3] = encodeImm(7, 1, 0, 3);
		prog[4] = encodeImm(9, 1, 0, 16'h84);
		prog[5] = encodeImm(63, 0, 0, 0);
		runTest("registerZero", 0);

		for (int t = 0; t < NUM_TESTS - 3; t++) begin
			makeRandomProgram();
			runTest($sformatf("random%0d", t), MAX_DELAY);
		end

		$display("Tests passed %0d, failed %0d, errors %0d", testsPassed, testsFailed, errors);
		if (errors == 0)
			$display("RESULT: PASS");
		else
			$display("RESULT: FAIL");
		$finish;
	end

endmodule

/* tb/tbMemory.sv */
// Instruction and data memories

`timescale 1ns/100ps
`include "coreSettings.svh"

module tbMemory (
	input logic clk,
	input logic rst_n,
	input int maxDelay,
	input pipePkg::instrReqT instrReq,
	output isaPkg::instrT instrData,
	output logic instrReady,
	input pipePkg::dataReqT dataReq,
	output logic [`XLEN-1:0] dataRdData,
	output logic dataReady
);

	logic [`XLEN-1:0] imem [256];
	logic [`XLEN-1:0] dmem [256];
	logic instrTaken;
	logic dataTaken;
	int instrWait;
	int dataWait;

	always @(posedge clk) begin
		instrTaken <= instrReq.valid && instrReady;
		dataTaken <= dataReq.valid && dataReady;
		if (dataReq.valid && dataReq.write && dataReady)
			dmem[dataReq.addr[9:2]] <= dataReq.wrData;
	end

	// New random delay after each completed access
	initial begin
		instrWait = 0;
		dataWait = 0;
		instrReady <= 1'b0;
		instrData <= '0;
		dataReady <= 1'b0;
		dataRdData <= '0;
		forever begin
			@(negedge clk);
			if (!rst_n) begin
				instrWait = 0;
				dataWait = 0;
			end else begin
				if (instrTaken)
					instrWait = $urandom_range(maxDelay, 0);
				else if (instrReq.valid && instrWait > 0)
					instrWait = instrWait - 1;
				if (dataTaken)
					dataWait = $urandom_range(maxDelay, 0);
				else if (dataReq.valid && dataWait > 0)
					dataWait = dataWait - 1;
			end
			instrReady <= rst_n && instrWait == 0;
			instrData <= imem[instrReq.addr[9:2]];
			dataReady <= rst_n && dataWait == 0;
			dataRdData <= dmem[dataReq.addr[9:2]];
		end
	end

endmodule

/* logic/pipelineCore.sv */
// Five-stage pipeline top

`timescale 1ns/100ps
`include "coreSettings.svh"

module pipelineCore (
	input logic clk,
	input logic rst_n,
	output pipePkg::instrReqT instrReq,
	input isaPkg::instrT instrData,
	input logic instrReady,
	output pipePkg::dataReqT dataReq,
	input logic [`XLEN-1:0] dataRdData,
	input logic dataReady,
	output logic halt
);
	import isaPkg::*;
	import pipePkg::*;

	stallT stall;
	instrT fetched;
	logic haltDecoded;
	decodedT idDecoded;
	decodedT exStage;
	execT exResult;
	execT memStage;
	writeBackT memResult;
	writeBackT wbStage;
	logic memBusy;

	fetchUnit fetch (
		.clk(clk),
		.rst_n(rst_n),
		.stall(stall),
		.haltDecoded(haltDecoded),
		.instrReq(instrReq),
		.instrData(instrData),
		.instrReady(instrReady),
		.fetched(fetched)
	);

	decodeUnit decode (
		.clk(clk),
		.rst_n(rst_n),
		.fetched(fetched),
		.writeBack(wbStage),
		.decoded(idDecoded),
		.haltDecoded(haltDecoded)
	);

	pipeStageReg #(.payloadT(decodedT)) idExReg (
		.clk(clk),
		.rst_n(rst_n),
		.stall(stall.freeze),
		.bubble(stall.bubbleEx),
		.in(idDecoded),
		.out(exStage)
	);

	executeUnit execute (
		.decodedIn(exStage),
		.memStage(memStage),
		.wbStage(wbStage),
		.executed(exResult)
	);

	pipeStageReg #(.payloadT(execT)) exMemReg (
		.clk(clk),
		.rst_n(rst_n),
		.stall(stall.freeze),
		.bubble(1'b0),
		.in(exResult),
		.out(memStage)
	);

	memoryUnit memory (
		.memStage(memStage),
		.dataReq(dataReq),
		.dataRdData(dataRdData),
		.dataReady(dataReady),
		.memBusy(memBusy),
		.writeBack(memResult)
	);

	pipeStageReg #(.payloadT(writeBackT)) memWbReg (
		.clk(clk),
		.rst_n(rst_n),
		.stall(stall.freeze),
		.bubble(1'b0),
		.in(memResult),
		.out(wbStage)
	);

	hazardControl hazard (
		.decoded(idDecoded),
		.exStage(exStage),
		.memBusy(memBusy),
		.stall(stall)
	);

	// Sticky until reset
	always_ff @(posedge clk) begin
		if (!rst_n)
			halt <= 1'b0;
		else
			halt <= halt || wbStage.isHalt;
	end

	// Freeze keeps the memory-stage register and so the request steady
	dataReqHeld: assert property (@(posedge clk) disable iff (!rst_n)
		dataReq.valid && !dataReady |=> $stable(dataReq));

endmodule

/* logic/hazardControl.sv */
// Stall control for the pipeline

`timescale 1ns/100ps
`include "coreSettings.svh"

module hazardControl (
	input pipePkg::decodedT decoded,
	input pipePkg::decodedT exStage,
	input logic memBusy,
	output pipePkg::stallT stall
);

	logic matchA;
	logic matchB;
	logic loadUse;

	// Load in execute feeding the instruction in decode
	assign matchA = decoded.srcAUsed && decoded.srcA == exStage.dest;
	assign matchB = decoded.srcBUsed && decoded.srcB == exStage.dest;
	assign loadUse = exStage.isLoad && exStage.destWe && (matchA || matchB);

	// Freeze overrides the load-use controls
	always_comb begin
		stall.freeze = memBusy;
		stall.holdFront = loadUse && !memBusy;
		stall.bubbleEx = loadUse && !memBusy;
	end

endmodule

/* logic/memoryUnit.sv */
// Memory stage and data port

`timescale 1ns/100ps
`include "coreSettings.svh"

module memoryUnit (
	input pipePkg::execT memStage,
	output pipePkg::dataReqT dataReq,
	input logic [`XLEN-1:0] dataRdData,
	input logic dataReady,
	output logic memBusy,
	output pipePkg::writeBackT writeBack
);

	always_comb begin
		dataReq.addr = memStage.result;
		dataReq.wrData = memStage.storeData;
		dataReq.write = memStage.isStore;
		dataReq.valid = memStage.isLoad || memStage.isStore;
	end

	// Whole pipeline freezes on this
	assign memBusy = dataReq.valid && !dataReady;

	always_comb begin
		writeBack.data = memStage.isLoad ? dataRdData : memStage.result;
		writeBack.dest = memStage.dest;
		writeBack.destWe = memStage.destWe;
		writeBack.isHalt = memStage.isHalt;
	end

endmodule

/* logic/executeUnit.sv */
// Execute stage with operand forwarding

`timescale 1ns/100ps
`include "coreSettings.svh"

module executeUnit (
	input pipePkg::decodedT decodedIn,
	input pipePkg::execT memStage,
	input pipePkg::writeBackT wbStage,
	output pipePkg::execT executed
);
	import isaPkg::*;

	logic [`XLEN-1:0] srcAVal;
	logic [`XLEN-1:0] srcBVal;
	logic [`XLEN-1:0] aluB;
	logic [`XLEN-1:0] aluOut;

	// Memory stage wins over write-back; loads only come from write-back
	function automatic logic [`XLEN-1:0] pickOperand(
		input regIdxT idx,
		input logic [`XLEN-1:0] regVal
	);
		if (memStage.destWe && !memStage.isLoad && memStage.dest == idx)
			return memStage.result;
		if (wbStage.destWe && wbStage.dest == idx)
			return wbStage.data;
		return regVal;
	endfunction

	assign srcAVal = pickOperand(decodedIn.srcA, decodedIn.opA);
	assign srcBVal = pickOperand(decodedIn.srcB, decodedIn.opB);
	assign aluB = decodedIn.useImm ? decodedIn.imm : srcBVal;

	always_comb begin
		case (decodedIn.aluOp)
			aluAdd: aluOut = srcAVal + aluB;
			aluSub: aluOut = srcAVal - aluB;
			aluAnd: aluOut = srcAVal & aluB;
			aluOr: aluOut = srcAVal | aluB;
			aluXor: aluOut = srcAVal ^ aluB;
			aluSlt: aluOut = {{(`XLEN-1){1'b0}}, $signed(srcAVal) < $signed(aluB)};
			default: aluOut = '0;
		endcase
	end

	always_comb begin
		executed.result = aluOut;
		executed.storeData = srcBVal;
		executed.dest = decodedIn.dest;
		executed.destWe = decodedIn.destWe;
		executed.isLoad = decodedIn.isLoad;
		executed.isStore = decodedIn.isStore;
		executed.isHalt = decodedIn.isHalt;
	end

endmodule

/* logic/decodeUnit.sv */
// Instruction decode and register file

`timescale 1ns/100ps
`include "coreSettings.svh"

module decodeUnit (
	input logic clk,
	input logic rst_n,
	input isaPkg::instrT fetched,
	input pipePkg::writeBackT writeBack,
	output pipePkg::decodedT decoded,
	output logic haltDecoded
);
	import isaPkg::*;

	logic [`XLEN-1:0] regFile [`REG_COUNT];
	logic isRegOp;

	// Write-before-read bypass with register 0 hardwired to zero
	function automatic logic [`XLEN-1:0] readReg(input regIdxT idx);
		if (idx == '0)
			return '0;
		if (writeBack.destWe && writeBack.dest == idx)
			return writeBack.data;
		return regFile[idx];
	endfunction

	always_ff @(posedge clk) begin
		if (rst_n && writeBack.destWe && writeBack.dest != '0)
			regFile[writeBack.dest] <= writeBack.data;
	end

	assign haltDecoded = fetched.opcode == opHalt;
	assign isRegOp = fetched.opcode inside {opAdd, opSub, opAnd, opOr, opXor, opSlt};

	always_comb begin
		case (fetched.opcode)
			opAdd: decoded.aluOp = aluAdd;
			opSub: decoded.aluOp = aluSub;
			opAnd: decoded.aluOp = aluAnd;
			opOr: decoded.aluOp = aluOr;
			opXor: decoded.aluOp = aluXor;
			opSlt: decoded.aluOp = aluSlt;
			opAddi, opLw, opSw: decoded.aluOp = aluAdd;
			default: decoded.aluOp = aluZero;
		endcase

		decoded.isLoad = fetched.opcode == opLw;
		decoded.isStore = fetched.opcode == opSw;
		decoded.isHalt = haltDecoded;
		decoded.useImm = fetched.opcode inside {opAddi, opLw, opSw};

		decoded.srcA = fetched.rs;
		decoded.srcAUsed = isRegOp || decoded.useImm;
		// SW reads its data from rd
		decoded.srcB = decoded.isStore ? fetched.rd : fetched.tail.r.rt;
		decoded.srcBUsed = isRegOp || decoded.isStore;

		decoded.dest = fetched.rd;
		decoded.destWe = (isRegOp || fetched.opcode inside {opAddi, opLw})
			&& fetched.rd != '0;

		decoded.imm = {{(`XLEN-16){fetched.tail.imm[15]}}, fetched.tail.imm};
		decoded.opA = readReg(decoded.srcA);
		decoded.opB = readReg(decoded.srcB);
	end

endmodule

/* logic/fetchUnit.sv */
// Instruction fetch stage

`timescale 1ns/100ps
`include "coreSettings.svh"

module fetchUnit (
	input logic clk,
	input logic rst_n,
	input pipePkg::stallT stall,
	input logic haltDecoded,
	output pipePkg::instrReqT instrReq,
	input isaPkg::instrT instrData,
	input logic instrReady,
	output isaPkg::instrT fetched
);

	logic [`XLEN-1:0] pc;
	logic fetchOn;
	logic haltSeen;
	logic fetchReq;
	logic advance;

	// Stop as soon as HALT sits in decode
	assign fetchReq = fetchOn && !haltSeen && !haltDecoded;
	assign advance = fetchReq && instrReady && !stall.freeze && !stall.holdFront;

	always_comb begin
		instrReq.addr = pc;
		instrReq.valid = fetchReq;
	end

	always_ff @(posedge clk) begin
		if (!rst_n) begin
			fetchOn <= 1'b0;
			haltSeen <= 1'b0;
		end else begin
			fetchOn <= 1'b1;
			if (haltDecoded)
				haltSeen <= 1'b1;
		end
	end

	// Missing ready becomes a bubble in decode
	always_ff @(posedge clk) begin
		if (!rst_n) begin
			pc <= `RESET_PC;
			fetched <= '0;
		end else if (!stall.freeze && !stall.holdFront) begin
			if (advance) begin
				pc <= pc + `PC_STEP;
				fetched <= instrData;
			end else begin
				fetched <= '0;
			end
		end
	end

	addrHeldUntilReady: assert property (@(posedge clk) disable iff (!rst_n)
		instrReq.valid && !instrReady |=> $stable(instrReq.addr));

endmodule

/* logic/pipeStageReg.sv */
// Generic pipeline stage register

`timescale 1ns/100ps
`include "coreSettings.svh"

module pipeStageReg #(
	parameter type payloadT = logic
) (
	input logic clk,
	input logic rst_n,
	input logic stall,
	input logic bubble,
	input payloadT in,
	output payloadT out
);

	// All-zero payload is a bubble
	always_ff @(posedge clk) begin
		if (!rst_n || bubble)
			out <= '0;
		else if (!stall)
			out <= in;
	end

	// Hazard logic never asks for both at once
	stallBubbleExclusive: assert property (@(posedge clk) disable iff (!rst_n)
		!(stall && bubble));

endmodule

/* logic/pipePkg.sv */
// Pipeline stage payload types

package pipePkg;
	import isaPkg::*;

	typedef logic [31:0] wordT;

	typedef struct packed {
		wordT addr;
		logic valid;
	} instrReqT;

	typedef struct packed {
		wordT addr;
		wordT wrData;
		logic write;
		logic valid;
	} dataReqT;

	// Decode to execute
	typedef struct packed {
		wordT opA;
		wordT opB;
		wordT imm;
		regIdxT srcA;
		logic srcAUsed;
		regIdxT srcB;
		logic srcBUsed;
		regIdxT dest;
		logic destWe;
		aluOpT aluOp;
		logic useImm;
		logic isLoad;
		logic isStore;
		logic isHalt;
	} decodedT;

	// Execute to memory with the result doubling as the data address
	typedef struct packed {
		wordT result;
		wordT storeData;
		regIdxT dest;
		logic destWe;
		logic isLoad;
		logic isStore;
		logic isHalt;
	} execT;

	typedef struct packed {
		wordT data;
		regIdxT dest;
		logic destWe;
		logic isHalt;
	} writeBackT;

	typedef struct packed {
		logic freeze;
		logic holdFront;
		logic bubbleEx;
	} stallT;

endpackage

/* logic/isaPkg.sv */
// Instruction set types

package isaPkg;

	// Opcodes not listed here behave as NOP
	typedef enum logic [5:0] {
		opNop = 6'd0,
		opAdd = 6'd1,
		opSub = 6'd2,
		opAnd = 6'd3,
		opOr = 6'd4,
		opXor = 6'd5,
		opSlt = 6'd6,
		opAddi = 6'd7,
		opLw = 6'd8,
		opSw = 6'd9,
		opHalt = 6'd63
	} opcodeT;

	typedef logic [4:0] regIdxT;

	typedef struct packed {
		regIdxT rt;
		logic [10:0] spare;
	} rtTailT;

	// Low half is either the third register or the immediate
	typedef union packed {
		rtTailT r;
		logic [15:0] imm;
	} tailT;

	typedef struct packed {
		opcodeT opcode;
		regIdxT rd;
		regIdxT rs;
		tailT tail;
	} instrT;

	typedef enum logic [2:0] {
		aluAdd,
		aluSub,
		aluAnd,
		aluOr,
		aluXor,
		aluSlt,
		aluZero
	} aluOpT;

endpackage

/* include/coreSettings.svh */
// Core configuration macros

`ifndef CORE_SETTINGS_SVH
`define CORE_SETTINGS_SVH

// Data and address width
`define XLEN 32

`define REG_COUNT 32

// First fetch address and distance between instructions
`define RESET_PC 32'h0000_0000
`define PC_STEP 4

`endif
